//--- hdl/mem_pkg.sv
package mem_pkg;

	// byte address width and the number of byte offset bits inside one line
	localparam int unsigned ADDR_W = 20;
	localparam int unsigned LINE_OFFSET_W = 4;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [31:0] word_t;

	// word 0 of a line sits in bits 31:0
	typedef logic [127:0] line_t;

	typedef enum logic [1:0] {
		op_none,
		op_read,
		op_write_word,
		op_write_byte
	} mem_op_e;

	// a byte write takes its data from bits 7:0
	typedef struct packed {
		mem_op_e op;
		addr_t   addr;
		word_t   data;
	} mem_req_t;

	// ready pulses for one cycle and addr echoes the read address
	typedef struct packed {
		logic  ready;
		addr_t addr;
		line_t line;
	} mem_resp_t;

	typedef struct packed {
		addr_t addr;
		word_t data;
		logic  byte_en;
	} store_req_t;

endpackage

//--- hdl/cache_pkg.sv
package cache_pkg;

	import mem_pkg::*;

	typedef enum logic [1:0] {
		idle,
		refill_wait,
		respond
	} cache_state_e;

	// line address is the byte address without its offset inside the line
	typedef logic [ADDR_W-LINE_OFFSET_W-1:0] line_addr_t;

	// selects one of the four words of a line
	typedef logic [LINE_OFFSET_W-3:0] word_sel_t;

	// valid pulses once at the end of every fetch
	typedef struct packed {
		logic  valid;
		logic  hit;
		word_t word;
	} fetch_resp_t;

endpackage

//--- hdl/line_memory.sv
module line_memory
	import mem_pkg::*;
#(
	parameter int unsigned MEM_LINES = 4096
) (
	input  logic      clk,
	input  logic      rst_n_i,
	input  mem_req_t  req_i,
	output mem_resp_t resp_o
);

	localparam int unsigned IDX_W = $clog2(MEM_LINES);

	line_t mem_q [MEM_LINES];

	logic [IDX_W-1:0] idx;
	logic [6:0]       word_bit;
	logic [6:0]       byte_bit;

	logic  ready_q;
	addr_t addr_q;
	line_t line_q;

	// line address bits above the memory depth are dropped so addresses wrap
	assign idx = req_i.addr[LINE_OFFSET_W +: IDX_W];

	// bit offsets of the selected word and byte inside the line
	assign word_bit = {req_i.addr[LINE_OFFSET_W-1:2], 5'b00000};
	assign byte_bit = {req_i.addr[LINE_OFFSET_W-1:0], 3'b000};

	// writes land at the edge where they are sampled
	always_ff @(posedge clk) begin
		case (req_i.op)
			op_write_word: begin
				mem_q[idx][word_bit +: 32] <= req_i.data;
			end
			op_write_byte: begin
				mem_q[idx][byte_bit +: 8] <= req_i.data[7:0];
			end
			default: begin
			end
		endcase
	end

	// a read sampled at one edge is presented after the next one
	always_ff @(posedge clk) begin
		if (req_i.op == op_read) begin
			addr_q <= req_i.addr;
			line_q <= mem_q[idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= (req_i.op == op_read);
		end
	end

	assign resp_o.ready = ready_q;
	assign resp_o.addr  = addr_q;
	assign resp_o.line  = line_q;

endmodule

//--- hdl/mem_arbiter.sv
module mem_arbiter
	import mem_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       refill_valid_i,
	input  addr_t      refill_addr_i,
	input  logic       store_valid_i,
	input  store_req_t store_req_i,
	output logic       store_ready_o,
	output mem_req_t   mem_req_o,
	input  mem_resp_t  mem_resp_i,
	output mem_resp_t  refill_resp_o,
	output logic       inval_valid_o,
	output addr_t      inval_addr_o
);

	logic read_out_q;
	logic issue_read;
	logic issue_store;

	// only one read may be in flight, and the cache holds its request until the answer
	assign issue_read = refill_valid_i && !read_out_q;

	// stores wait out the whole refill so the returned line is never stale
	assign store_ready_o = !refill_valid_i && !read_out_q;
	assign issue_store   = store_valid_i && store_ready_o;

	always_comb begin
		mem_req_o.op   = op_none;
		mem_req_o.addr = '0;
		mem_req_o.data = '0;
		if (issue_read) begin
			mem_req_o.op   = op_read;
			mem_req_o.addr = refill_addr_i;
		end else if (issue_store) begin
			mem_req_o.op   = store_req_i.byte_en ? op_write_byte : op_write_word;
			mem_req_o.addr = store_req_i.addr;
			mem_req_o.data = store_req_i.data;
		end
	end

	// the memory answers one cycle after the read, which closes the window
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			read_out_q <= 1'b0;
		end else if (issue_read) begin
			read_out_q <= 1'b1;
		end else if (mem_resp_i.ready) begin
			read_out_q <= 1'b0;
		end
	end

	// the cache is the only reader, so every response belongs to it
	assign refill_resp_o = mem_resp_i;

	// a store drops any cached copy of its line at the same edge it is written
	assign inval_valid_o = issue_store;
	assign inval_addr_o  = store_req_i.addr;

endmodule

//--- hdl/fetch_cache.sv
module fetch_cache
	import mem_pkg::*;
	import cache_pkg::*;
#(
	parameter int unsigned CACHE_LINES = 16
) (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        fetch_valid_i,
	input  addr_t       fetch_addr_i,
	output logic        fetch_ready_o,
	output fetch_resp_t fetch_resp_o,
	output logic        refill_valid_o,
	output addr_t       refill_addr_o,
	input  mem_resp_t   refill_resp_i,
	input  logic        inval_valid_i,
	input  addr_t       inval_addr_i
);

	localparam int unsigned INDEX_W = $clog2(CACHE_LINES);
	localparam int unsigned TAG_W = $bits(line_addr_t) - INDEX_W;

	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_W-1:0] tag_t;

	cache_state_e state_q;

	logic [CACHE_LINES-1:0] valid_q;
	tag_t                   tag_q [CACHE_LINES];
	line_t                  line_q [CACHE_LINES];

	// the accepted fetch and the answer that goes with it
	addr_t addr_q;
	logic  hit_q;
	word_t word_q;

	line_addr_t fetch_line;
	line_addr_t inval_line;
	line_addr_t fill_line;
	index_t     fetch_index;
	index_t     inval_index;
	index_t     fill_index;
	tag_t       fetch_tag;
	tag_t       inval_tag;
	tag_t       fill_tag;

	logic fetch_accept;
	logic lookup_hit;
	logic inval_match;
	logic fill_done;

	function automatic word_t select_word(line_t line, word_sel_t sel);
		return line[{sel, 5'b00000} +: 32];
	endfunction

	assign fetch_line = fetch_addr_i[ADDR_W-1:LINE_OFFSET_W];
	assign inval_line = inval_addr_i[ADDR_W-1:LINE_OFFSET_W];
	assign fill_line  = refill_resp_i.addr[ADDR_W-1:LINE_OFFSET_W];

	// low line address bits pick the entry and the rest form the tag
	assign fetch_index = fetch_line[INDEX_W-1:0];
	assign inval_index = inval_line[INDEX_W-1:0];
	assign fill_index  = fill_line[INDEX_W-1:0];
	assign fetch_tag   = fetch_line[$bits(line_addr_t)-1 -: TAG_W];
	assign inval_tag   = inval_line[$bits(line_addr_t)-1 -: TAG_W];
	assign fill_tag    = fill_line[$bits(line_addr_t)-1 -: TAG_W];

	assign fetch_ready_o = (state_q == idle);
	assign fetch_accept  = fetch_valid_i && fetch_ready_o;

	// a store to the same line in the same cycle turns the lookup into a miss
	// so that the refill reads the freshly written data
	assign lookup_hit = valid_q[fetch_index] && (tag_q[fetch_index] == fetch_tag) &&
		!(inval_valid_i && (inval_line == fetch_line));

	assign inval_match = inval_valid_i && (tag_q[inval_index] == inval_tag);
	assign fill_done   = (state_q == refill_wait) && refill_resp_i.ready;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= idle;
			valid_q <= '0;
		end else begin
			case (state_q)
				idle: begin
					if (fetch_accept) begin
						state_q <= lookup_hit ? respond : refill_wait;
					end
				end
				refill_wait: begin
					if (refill_resp_i.ready) begin
						state_q <= respond;
					end
				end
				respond: begin
					state_q <= idle;
				end
				default: begin
					state_q <= idle;
				end
			endcase
			if (fill_done) begin
				valid_q[fill_index] <= 1'b1;
			end
			// stores are held off during a refill, so a fill and an invalidation never meet
			if (inval_match) begin
				valid_q[inval_index] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_accept) begin
			addr_q <= fetch_addr_i;
			hit_q  <= lookup_hit;
			word_q <= select_word(line_q[fetch_index], fetch_addr_i[LINE_OFFSET_W-1:2]);
		end
		if (fill_done) begin
			tag_q[fill_index]  <= fill_tag;
			line_q[fill_index] <= refill_resp_i.line;
			word_q             <= select_word(refill_resp_i.line, addr_q[LINE_OFFSET_W-1:2]);
		end
	end

	// the request stays up until the line returns and the arbiter issues it once
	assign refill_valid_o = (state_q == refill_wait);
	assign refill_addr_o  = addr_q;

	assign fetch_resp_o.valid = (state_q == respond);
	assign fetch_resp_o.hit   = hit_q;
	assign fetch_resp_o.word  = word_q;

endmodule

//--- hdl/mem_subsys.sv
module mem_subsys
	import mem_pkg::*;
	import cache_pkg::*;
#(
	parameter int unsigned MEM_LINES   = 4096,
	parameter int unsigned CACHE_LINES = 16
) (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        fetch_valid_i,
	input  addr_t       fetch_addr_i,
	output logic        fetch_ready_o,
	output fetch_resp_t fetch_resp_o,
	input  logic        store_valid_i,
	input  store_req_t  store_req_i,
	output logic        store_ready_o
);

	logic      refill_valid;
	addr_t     refill_addr;
	mem_resp_t refill_resp;
	logic      inval_valid;
	addr_t     inval_addr;
	mem_req_t  mem_req;
	mem_resp_t mem_resp;

	fetch_cache #(
		.CACHE_LINES (CACHE_LINES)
	) u_fetch_cache (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.fetch_valid_i  (fetch_valid_i),
		.fetch_addr_i   (fetch_addr_i),
		.fetch_ready_o  (fetch_ready_o),
		.fetch_resp_o   (fetch_resp_o),
		.refill_valid_o (refill_valid),
		.refill_addr_o  (refill_addr),
		.refill_resp_i  (refill_resp),
		.inval_valid_i  (inval_valid),
		.inval_addr_i   (inval_addr)
	);

	// stores bypass the cache and go straight to the memory port
	mem_arbiter u_mem_arbiter (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.refill_valid_i (refill_valid),
		.refill_addr_i  (refill_addr),
		.store_valid_i  (store_valid_i),
		.store_req_i    (store_req_i),
		.store_ready_o  (store_ready_o),
		.mem_req_o      (mem_req),
		.mem_resp_i     (mem_resp),
		.refill_resp_o  (refill_resp),
		.inval_valid_o  (inval_valid),
		.inval_addr_o   (inval_addr)
	);

	line_memory #(
		.MEM_LINES (MEM_LINES)
	) u_line_memory (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (mem_req),
		.resp_o  (mem_resp)
	);

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
	end

	always #5 clk_o = ~clk_o;

	// reset is released on a falling edge after three rising edges
	initial begin
		rst_n_o = 1'b0;
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

//--- sim/mem_subsys_properties.sv
module mem_subsys_properties
	import mem_pkg::*;
(
	input logic      clk,
	input logic      rst_n_i,
	input mem_req_t  mem_req_i,
	input mem_resp_t mem_resp_i,
	input logic      store_ready_i
);

	int unsigned fail_count = 0;

	// every read is answered on the next cycle by a ready pulse one cycle wide
	ready_after_read: assert property (@(posedge clk) disable iff (!rst_n_i)
		(mem_req_i.op == op_read) |=> mem_resp_i.ready ##1 !mem_resp_i.ready)
		else begin
			fail_count++;
			$error("ready pulse missing or longer than one cycle after a read");
		end

	// the cycle after a read is issued still waits for its answer
	store_held_off: assert property (@(posedge clk) disable iff (!rst_n_i)
		(mem_req_i.op == op_read) |=> !store_ready_i)
		else begin
			fail_count++;
			$error("store_ready_o high while a read is outstanding");
		end

	// a write here could change the line before its refill data comes back
	no_write_in_read: assert property (@(posedge clk) disable iff (!rst_n_i)
		(mem_req_i.op == op_read) |=> !(mem_req_i.op inside {op_write_word, op_write_byte}))
		else begin
			fail_count++;
			$error("write issued while a read is outstanding");
		end

endmodule

bind mem_arbiter mem_subsys_properties u_props (
	.clk           (clk),
	.rst_n_i       (rst_n_i),
	.mem_req_i     (mem_req_o),
	.mem_resp_i    (mem_resp_i),
	.store_ready_i (store_ready_o)
);

//--- sim/tb_mem_subsys.sv
module tb_mem_subsys
	import mem_pkg::*;
	import cache_pkg::*;
();

	localparam int TIMEOUT = 50;

	logic        clk;
	logic        rst_n;
	logic        fetch_valid;
	addr_t       fetch_addr;
	logic        fetch_ready;
	fetch_resp_t fetch_resp;
	logic        store_valid;
	store_req_t  store_req;
	logic        store_ready;

	// byte-addressed model of the first 64 KiB, which is the whole memory depth
	logic [7:0] ref_mem [65536];
	integer     seed;

	tb_clock_gen u_clock_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	mem_subsys #(
		.MEM_LINES   (4096),
		.CACHE_LINES (16)
	) uut (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.fetch_valid_i (fetch_valid),
		.fetch_addr_i  (fetch_addr),
		.fetch_ready_o (fetch_ready),
		.fetch_resp_o  (fetch_resp),
		.store_valid_i (store_valid),
		.store_req_i   (store_req),
		.store_ready_o (store_ready)
	);

	task automatic stop_on_error();
		$display("tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_timeout(string what);
		$display("timeout while waiting for %s", what);
		stop_on_error();
	endtask

	task automatic compare_word(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
			stop_on_error();
		end
	endtask

	task automatic compare_hit(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("FAIL time %0t %s expected %b actual %b", $time, name, expected, actual);
			stop_on_error();
		end
	endtask

	task automatic compare_cycles(string name, int expected, int actual);
		if (actual != expected) begin
			$display("FAIL time %0t %s expected %0d actual %0d", $time, name, expected, actual);
			stop_on_error();
		end
	endtask

	task automatic update_ref(addr_t addr, word_t data, logic byte_en);
		if (byte_en) begin
			ref_mem[addr[15:0]] = data[7:0];
		end else begin
			for (int i = 0; i < 4; i++) begin
				ref_mem[{addr[15:2], 2'(i)}] = data[8*i +: 8];
			end
		end
	endtask

	// byte 0 of the word sits in its low bits
	function automatic word_t ref_word(addr_t addr);
		word_t w;
		for (int i = 0; i < 4; i++) begin
			w[8*i +: 8] = ref_mem[{addr[15:2], 2'(i)}];
		end
		return w;
	endfunction

	// all request tasks start and end on a falling edge
	task automatic issue_store(addr_t addr, word_t data, logic byte_en);
		int waited;
		waited = 0;
		store_valid = 1'b1;
		store_req = '{addr: addr, data: data, byte_en: byte_en};
		while (!store_ready) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) report_timeout("store_ready_o");
		end
		@(posedge clk);
		update_ref(addr, data, byte_en);
		@(negedge clk);
		store_valid = 1'b0;
	endtask

	// cycles counts from the accepting edge to the response
	task automatic issue_fetch(addr_t addr, output word_t word, output logic hit,
			output int cycles);
		int waited;
		waited = 0;
		fetch_valid = 1'b1;
		fetch_addr = addr;
		while (!fetch_ready) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) report_timeout("fetch_ready_o");
		end
		@(negedge clk);
		fetch_valid = 1'b0;
		cycles = 1;
		while (!fetch_resp.valid) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) report_timeout("fetch_resp_o.valid");
		end
		word = fetch_resp.word;
		hit = fetch_resp.hit;
	endtask

	task automatic fill_line(addr_t base);
		for (int i = 0; i < 4; i++) begin
			issue_store(base + addr_t'(4 * i), $random(seed), 1'b0);
		end
	endtask

	task automatic test_cold_fetch();
		word_t word;
		logic  hit;
		int    cycles;
		fill_line(20'h00040);
		for (int i = 0; i < 4; i++) begin
			issue_fetch(20'h00040 + addr_t'(4 * i), word, hit, cycles);
			compare_word("fetch_resp_o.word", ref_word(20'h00040 + addr_t'(4 * i)), word);
			compare_hit("fetch_resp_o.hit", (i != 0), hit);
			if (i == 0) compare_cycles("miss latency", 3, cycles);
		end
	endtask

	task automatic test_hit_path();
		word_t word;
		logic  hit;
		int    cycles;
		fill_line(20'h00080);
		issue_fetch(20'h00088, word, hit, cycles);
		compare_word("fetch_resp_o.word", ref_word(20'h00088), word);
		issue_fetch(20'h00088, word, hit, cycles);
		compare_hit("fetch_resp_o.hit", 1'b1, hit);
		compare_cycles("hit latency", 1, cycles);
		compare_word("fetch_resp_o.word", ref_word(20'h00088), word);
	endtask

	task automatic test_byte_store();
		word_t word;
		word_t expected;
		logic  hit;
		int    cycles;
		fill_line(20'h000c0);
		issue_fetch(20'h000c4, word, hit, cycles);
		compare_word("fetch_resp_o.word", ref_word(20'h000c4), word);
		expected = ref_word(20'h000c4);
		expected[23:16] = 8'h5a;
		issue_store(20'h000c6, 32'h0000005a, 1'b1);
		issue_fetch(20'h000c4, word, hit, cycles);
		compare_hit("fetch_resp_o.hit", 1'b0, hit);
		compare_word("fetch_resp_o.word", expected, word);
	endtask

	// a store presented during a refill has to wait for the line to come back
	task automatic test_back_pressure();
		word_t old_word;
		word_t word;
		logic  hit;
		int    cycles;
		int    waited;
		fill_line(20'h00100);
		old_word = ref_word(20'h00104);
		compare_hit("fetch_ready_o", 1'b1, fetch_ready);
		fetch_valid = 1'b1;
		fetch_addr = 20'h00104;
		@(negedge clk);
		fetch_valid = 1'b0;
		store_valid = 1'b1;
		store_req = '{addr: 20'h00104, data: 32'hc0ffee11, byte_en: 1'b0};
		compare_hit("store_ready_o", 1'b0, store_ready);
		waited = 0;
		while (!store_ready) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) report_timeout("store_ready_o after refill");
		end
		compare_hit("fetch_resp_o.valid", 1'b1, fetch_resp.valid);
		compare_hit("fetch_resp_o.hit", 1'b0, fetch_resp.hit);
		compare_word("fetch_resp_o.word", old_word, fetch_resp.word);
		@(posedge clk);
		update_ref(20'h00104, 32'hc0ffee11, 1'b0);
		@(negedge clk);
		store_valid = 1'b0;
		issue_fetch(20'h00104, word, hit, cycles);
		compare_word("fetch_resp_o.word", ref_word(20'h00104), word);
	endtask

	// the first three lines share cache index 0 and the last one uses index 1
	task automatic test_random_mix();
		addr_t       lines [4];
		addr_t       addr;
		logic [31:0] r;
		word_t       word;
		logic        hit;
		int          cycles;
		lines = '{20'h00400, 20'h00800, 20'h00c00, 20'h00410};
		for (int i = 0; i < 4; i++) begin
			fill_line(lines[i]);
		end
		for (int n = 0; n < 200; n++) begin
			r = $random(seed);
			addr = lines[r[1:0]] | {16'h0000, r[3:2], r[5:4]};
			case (r[7:6])
				2'd2: issue_store({addr[19:2], 2'b00}, $random(seed), 1'b0);
				2'd3: issue_store(addr, $random(seed), 1'b1);
				default: begin
					issue_fetch(addr, word, hit, cycles);
					compare_word("fetch_resp_o.word", ref_word(addr), word);
				end
			endcase
		end
	endtask

	initial begin
		int waited;
		seed = 32'hfae1e6e6;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		store_valid = 1'b0;
		store_req = '0;
		waited = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) report_timeout("reset release");
		end
		test_cold_fetch();
		test_hit_path();
		test_byte_store();
		test_back_pressure();
		test_random_mix();
		@(negedge clk);
		if (uut.u_mem_arbiter.u_props.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			stop_on_error();
		end
	end

endmodule

//--- mem_subsys.f
hdl/mem_pkg.sv
hdl/cache_pkg.sv
hdl/line_memory.sv
hdl/mem_arbiter.sv
hdl/fetch_cache.sv
hdl/mem_subsys.sv
sim/tb_clock_gen.sv
sim/mem_subsys_properties.sv
sim/tb_mem_subsys.sv
